//--- testbench/testdata.txt
# name opcode(0 add,1 sub,2 and,3 or,4 xor,5 shl,6 ldi) dest srcA srcB immediate expected gap
# All fields hex except gap, the idle cycles before issue in decimal (0-3, or 9 for the LFSR)
ldiR1 6 1 0 0 1234 1234 2
ldiR2 6 2 0 0 0101 0101 2
addRegFile 0 3 1 2 0000 1335 3
addFwdExA 0 4 3 1 0000 2569 0
subFwdExB 1 5 1 4 0000 eccb 0
ldiR6 6 6 0 0 00f0 00f0 2
ldiR7 6 7 0 0 0f0f 0f0f 0
andFwdWbA 2 8 6 5 0000 00c0 0
orFwdWbB 3 9 1 7 0000 1f3f 0
ldiR10Old 6 a 0 0 1111 1111 2
ldiR10New 6 a 0 0 2222 2222 0
addPriorityBoth 0 b a a 0000 4444 0
ldiR12Old 6 c 0 0 00ff 00ff 2
ldiR12New 6 c 0 0 0f00 0f00 0
xorPriorityB 4 d 9 c 0000 103f 0
shlRegFile 5 e 2 3 0000 2020 9
shlFwdEx 5 f e 1 0000 0200 0
ldiStale 6 1 f e beef beef 0
addAfterLdi 0 2 1 0 0000 beef 0
subRand 1 3 2 f 0000 bcef 9
andRand 2 4 3 5 0000 accb 9
orRand 3 5 4 7 0000 afcf 9
xorSelf 4 6 5 5 0000 0000 9
addRand 0 7 6 d 0000 103f 9
shlRand 5 8 7 b 0000 03f0 9
subWrap 1 9 8 7 0000 f3b1 9
addDouble 0 a 9 9 0000 e762 9
ldiRand 6 b 0 0 7fff 7fff 9
addCarryOut 0 c b 1 0000 3eee 9
xorIntoR0 4 0 c a 0000 d98c 9
orFwdEx 3 d 0 2 0000 ffef 0
andFwdWb 2 e d 0 0000 d98c 1

//--- all.f
hw/DatapathPkg.sv
hw/AluPkg.sv
hw/OperandPort.sv
hw/RegisterFile.sv
hw/OperandForwarder.sv
hw/ExecuteStage.sv
hw/ForwardingDatapath.sv
testbench/DatapathTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = DatapathTb
FILELIST  = all.f
OBJDIR    = obj_dir
PASS_TEXT = Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

//--- testbench/DatapathTb.sv
module DatapathTb;
    timeunit 1ns;
    timeprecision 100ps;

    import DatapathPkg::*;
    import AluPkg::*;

    typedef struct {
        string                   name;
        OpcodeT                  opcode;
        logic [RegAddrWidth-1:0] dest;
        logic [RegAddrWidth-1:0] srcA;
        logic [RegAddrWidth-1:0] srcB;
        logic [DataWidth-1:0]    immediate;
        logic [DataWidth-1:0]    expected;
        int                      gap;
    } TestT;

    logic clk = 1'b0;
    logic reset;
    logic issueValid;
    OpcodeT opcode;
    logic [RegAddrWidth-1:0] destAddr;
    logic [RegAddrWidth-1:0] srcAAddr;
    logic [RegAddrWidth-1:0] srcBAddr;
    logic [DataWidth-1:0] immediate;
    logic resultValid;
    logic [RegAddrWidth-1:0] resultAddr;
    logic [DataWidth-1:0] resultData;

    TestT tests[$];
    // Outstanding results in issue order
    string expName[$];
    logic [RegAddrWidth-1:0] expAddr[$];
    logic [DataWidth-1:0] expData[$];
    int expCycle[$];

    int cycleCount = 0;
    int cycleLimit = 0;
    logic [31:0] lfsrState = 32'he8c8_5230;

    ForwardingDatapath dut0 (
        .clk         (clk),
        .reset       (reset),
        .issueValid  (issueValid),
        .opcode      (opcode),
        .destAddr    (destAddr),
        .srcAAddr    (srcAAddr),
        .srcBAddr    (srcBAddr),
        .immediate   (immediate),
        .resultValid (resultValid),
        .resultAddr  (resultAddr),
        .resultData  (resultData)
    );

    always #20 clk = ~clk;

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkData(input string testName, input logic [DataWidth-1:0] expected,
                             input logic [DataWidth-1:0] actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("error: %s data expected 0x%h actual 0x%h",
                                      testName, expected, actual));
        end
    endtask

    task automatic checkAddr(input string testName, input logic [RegAddrWidth-1:0] expected,
                             input logic [RegAddrWidth-1:0] actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("error: %s address expected 0x%h actual 0x%h",
                                      testName, expected, actual));
        end
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic loadTests();
        int fd;
        int fields;
        string line;
        TestT entry;
        logic [OpcodeWidth-1:0] opBits;
        fd = $fopen("testbench/testdata.txt", "r");
        if (fd == 0) begin
            stopWithFailure("Could not open testbench/testdata.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip blank lines and the column description
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h %d", entry.name, opBits,
                                     entry.dest, entry.srcA, entry.srcB, entry.immediate,
                                     entry.expected, entry.gap);
                    if (fields != 8) begin
                        stopWithFailure({"Test data line could not be parsed: ", line});
                    end else begin
                        entry.opcode = OpcodeT'(opBits);
                        tests.push_back(entry);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic checkResult();
        string name;
        logic [RegAddrWidth-1:0] addr;
        logic [DataWidth-1:0] data;
        int issuedAt;
        if (expName.size() == 0) begin
            stopWithFailure("A result was written back with no instruction outstanding");
        end else begin
            name = expName.pop_front();
            addr = expAddr.pop_front();
            data = expData.pop_front();
            issuedAt = expCycle.pop_front();
            if (cycleCount - issuedAt != 2) begin
                stopWithFailure($sformatf("Result of %s arrived %0d cycles after issue, not 2",
                                          name, cycleCount - issuedAt));
            end else begin
                checkAddr(name, addr, resultAddr);
                checkData(name, data, resultData);
            end
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            stopWithFailure($sformatf("Timeout after %0d cycles with %0d results missing",
                                      cycleCount, expName.size()));
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset && resultValid) begin
            checkResult();
        end
    end

    initial begin
        int gap;
        logic bitHi;
        logic bitLo;
        reset <= 1'b1;
        issueValid <= 1'b0;
        opcode <= OpAdd;
        destAddr <= '0;
        srcAAddr <= '0;
        srcBAddr <= '0;
        immediate <= '0;
        loadTests();
        if (tests.size() == 0) begin
            stopWithFailure("The test data file holds no instructions");
        end
        cycleLimit = 6 * tests.size() + 20;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        foreach (tests[i]) begin
            bitHi = lfsrState[0];
            lfsrState = stepLfsr(lfsrState);
            bitLo = lfsrState[0];
            lfsrState = stepLfsr(lfsrState);
            // Gap values above 3 leave the idle count to the LFSR
            gap = (tests[i].gap > 3) ? int'({bitHi, bitLo}) : tests[i].gap;
            repeat (gap) begin
                @(posedge clk);
                issueValid <= 1'b0;
            end
            @(posedge clk);
            issueValid <= 1'b1;
            opcode <= tests[i].opcode;
            destAddr <= tests[i].dest;
            srcAAddr <= tests[i].srcA;
            srcBAddr <= tests[i].srcB;
            immediate <= tests[i].immediate;
            @(negedge clk);
            expName.push_back(tests[i].name);
            expAddr.push_back(tests[i].dest);
            expData.push_back(tests[i].expected);
            expCycle.push_back(cycleCount);
        end
        @(posedge clk);
        issueValid <= 1'b0;
        while (expName.size() != 0) begin
            @(posedge clk);
        end
        // A few quiet cycles to catch a stray writeback
        repeat (3) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- hw/ForwardingDatapath.sv
module ForwardingDatapath (
    input  logic                                 clk,
    input  logic                                 reset,

    // Issue side
    input  logic                                 issueValid,
    input  AluPkg::OpcodeT                       opcode,
    input  logic [DatapathPkg::RegAddrWidth-1:0] destAddr,
    input  logic [DatapathPkg::RegAddrWidth-1:0] srcAAddr,
    input  logic [DatapathPkg::RegAddrWidth-1:0] srcBAddr,
    input  logic [DatapathPkg::DataWidth-1:0]    immediate,

    // Result as it is written back
    output logic                                 resultValid,
    output logic [DatapathPkg::RegAddrWidth-1:0] resultAddr,
    output logic [DatapathPkg::DataWidth-1:0]    resultData
);
    import DatapathPkg::*;
    import AluPkg::*;

    logic                          readEn;
    logic [1:0][RegAddrWidth-1:0] srcAddr;

    logic                    exValid;
    logic [RegAddrWidth-1:0] exAddr;
    logic [DataWidth-1:0]    exData;
    logic                    wbValid;
    logic [RegAddrWidth-1:0] wbAddr;
    logic [DataWidth-1:0]    wbData;

    // Index 0 is port A, index 1 is port B
    OperandPort operandPorts [2] ();

    // Load-immediate reads no sources, so it must not pick up a forward
    assign readEn = issueValid && (opcode != OpLoadImm);
    assign srcAddr = {srcBAddr, srcAAddr};

    RegisterFile regFile (
        .clk       (clk),
        .reset     (reset),
        .portA     (operandPorts[0]),
        .portB     (operandPorts[1]),
        .writeEn   (wbValid),
        .writeAddr (wbAddr),
        .writeData (wbData)
    );

    for (genvar i = 0; i < 2; i++) begin : forwardPort
        assign operandPorts[i].readEn = readEn;
        assign operandPorts[i].addr   = srcAddr[i];

        OperandForwarder forwarder (
            .port    (operandPorts[i]),
            .exValid (exValid),
            .exAddr  (exAddr),
            .exData  (exData),
            .wbValid (wbValid),
            .wbAddr  (wbAddr),
            .wbData  (wbData)
        );
    end

    ExecuteStage execute (
        .clk        (clk),
        .reset      (reset),
        .issueValid (issueValid),
        .opcode     (opcode),
        .destAddr   (destAddr),
        .immediate  (immediate),
        .operandA   (operandPorts[0]),
        .operandB   (operandPorts[1]),
        .exValid    (exValid),
        .exAddr     (exAddr),
        .exData     (exData),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData)
    );

    assign resultValid = wbValid;
    assign resultAddr  = wbAddr;
    assign resultData  = wbData;

endmodule

//--- hw/ExecuteStage.sv
module ExecuteStage (
    input  logic                                 clk,
    input  logic                                 reset,

    // Issued instruction
    input  logic                                 issueValid,
    input  AluPkg::OpcodeT                       opcode,
    input  logic [DatapathPkg::RegAddrWidth-1:0] destAddr,
    input  logic [DatapathPkg::DataWidth-1:0]    immediate,

    // Forwarded operands
    OperandPort.consumer                         operandA,
    OperandPort.consumer                         operandB,

    // Registered ALU result (Forward0)
    output logic                                 exValid,
    output logic [DatapathPkg::RegAddrWidth-1:0] exAddr,
    output logic [DatapathPkg::DataWidth-1:0]    exData,

    // Writeback holding register (Forward1 and register file write)
    output logic                                 wbValid,
    output logic [DatapathPkg::RegAddrWidth-1:0] wbAddr,
    output logic [DatapathPkg::DataWidth-1:0]    wbData
);
    import DatapathPkg::*;
    import AluPkg::*;

    logic [DataWidth-1:0] a;
    logic [DataWidth-1:0] b;
    logic [DataWidth-1:0] aluResult;

    assign a = operandA.fwdData;
    assign b = operandB.fwdData;

    always_comb begin
        unique case (opcode)
            OpAdd:     aluResult = a + b;
            OpSub:     aluResult = a - b;
            OpAnd:     aluResult = a & b;
            OpOr:      aluResult = a | b;
            OpXor:     aluResult = a ^ b;
            OpShl:     aluResult = a << b[3:0];
            OpLoadImm: aluResult = immediate;
            default:   aluResult = '0;
        endcase
    end

    // Valid bits carry the pipeline state
    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            exValid <= issueValid;
            wbValid <= exValid;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        exAddr <= destAddr;
        exData <= aluResult;
        wbAddr <= exAddr;
        wbData <= exData;
    end

    // Only opcodes the ALU decodes may be issued
    assert property (@(posedge clk) disable iff (reset)
        issueValid |-> opcode inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpShl, OpLoadImm})
        else $error("Issued opcode is not one the ALU decodes");

    // An issued instruction carries a known destination and known operands
    assert property (@(posedge clk) disable iff (reset)
        issueValid |-> !$isunknown({destAddr, a, b}))
        else $error("Issued instruction has an unknown destination or operand");

endmodule

//--- hw/OperandForwarder.sv
module OperandForwarder (
    OperandPort.forwarder                        port,

    // Forward0 from the execute stage
    input  logic                                 exValid,
    input  logic [DatapathPkg::RegAddrWidth-1:0] exAddr,
    input  logic [DatapathPkg::DataWidth-1:0]    exData,

    // Forward1 from the writeback register
    input  logic                                 wbValid,
    input  logic [DatapathPkg::RegAddrWidth-1:0] wbAddr,
    input  logic [DatapathPkg::DataWidth-1:0]    wbData
);
    import DatapathPkg::*;

    logic                 exMatch;
    logic                 wbMatch;
    ForwardSourceT        sourceSel;
    logic [DataWidth-1:0] operand;

    assign exMatch = exValid && (exAddr == port.addr);
    assign wbMatch = wbValid && (wbAddr == port.addr);

    // Younger execute result first, then writeback, then the register file
    always_comb begin
        if (port.readEn && exMatch) begin
            sourceSel = SourceExecute;
        end else if (port.readEn && wbMatch) begin
            sourceSel = SourceWriteback;
        end else begin
            sourceSel = SourceRegFile;
        end
    end

    always_comb begin
        unique case (sourceSel)
            SourceExecute:   operand = exData;
            SourceWriteback: operand = wbData;
            default:         operand = port.regData;
        endcase
    end

    assign port.fwdData = operand;

endmodule

//--- hw/RegisterFile.sv
module RegisterFile (
    input  logic                                clk,
    input  logic                                reset,

    OperandPort.source                          portA,
    OperandPort.source                          portB,

    input  logic                                writeEn,
    input  logic [DatapathPkg::RegAddrWidth-1:0] writeAddr,
    input  logic [DatapathPkg::DataWidth-1:0]    writeData
);
    import DatapathPkg::*;

    logic [DataWidth-1:0] regs [RegCount];

    // Single write port whose value is readable the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Asynchronous read ports
    // The forwarders cover the write cycle so there is no internal bypass
    assign portA.regData = regs[portA.addr];
    assign portB.regData = regs[portB.addr];

endmodule

//--- hw/OperandPort.sv
interface OperandPort;
    import DatapathPkg::*;

    // Read request from the issue logic
    logic                    readEn;
    logic [RegAddrWidth-1:0] addr;
    // Raw register file value and the corrected operand
    logic [DataWidth-1:0]    regData;
    logic [DataWidth-1:0]    fwdData;

    // Register file fills in the raw read data
    modport source (input readEn, input addr, output regData);

    // Forwarder picks between the raw value and in-flight results
    modport forwarder (
        input  readEn,
        input  addr,
        input  regData,
        output fwdData
    );

    modport consumer (input fwdData);

endinterface

//--- hw/AluPkg.sv
package AluPkg;

    localparam int OpcodeWidth = 3;

    typedef enum logic [OpcodeWidth-1:0] {
        OpAdd,
        OpSub,
        OpAnd,
        OpOr,
        OpXor,
        // Shift amount is the low 4 bits of operand B
        OpShl,
        // Result is the immediate and no source registers are read
        OpLoadImm
    } OpcodeT;

endpackage

//--- hw/DatapathPkg.sv
package DatapathPkg;

    // Operand and result width
    localparam int DataWidth = 16;

    // Register file geometry
    localparam int RegAddrWidth = 4;
    localparam int RegCount = 2 ** RegAddrWidth;

    // Which value a forwarder picked for its operand
    typedef enum logic [1:0] {
        // Architectural value straight from the register file
        SourceRegFile,
        // Result registered by the execute stage last cycle (Forward0)
        SourceExecute,
        // Result waiting in the writeback register (Forward1)
        SourceWriteback
    } ForwardSourceT;

    // Forward0 is the younger result, so it wins when both
    // in-flight results target the same register

endpackage
